/* common/icache_pkg.sv */
`default_nettype none

package icache_pkg;

  // bus widths on both the cpu and memory side
  localparam int XLEN = 32;

  // address split, tag | index | byte offset
  localparam int TAG_W = 19;
  localparam int IDX_W = 7;
  localparam int OFS_W = 6;

  // one of the 16 words inside a 64 byte line
  localparam int WORD_SEL_W = 4;

  // 128 lines x 64 bytes = 8 KB, direct mapped
  localparam int NUM_LINES      = 128;
  localparam int WORDS_PER_LINE = 16;

  // memory burst length field, beats minus one
  localparam int MEM_LEN_W = 8;
  localparam logic [MEM_LEN_W-1:0] REFILL_LEN = 8'd15;
  localparam logic [MEM_LEN_W-1:0] SINGLE_LEN = 8'd0;

  // device window, address bits 31..28
  // never stored in the arrays
  localparam logic [3:0] UNCACHED_REGION = 4'h1;

  // controller states
  typedef enum logic [2:0] {
    RESET,
    IDLE,
    LOOKUP,
    MISS,
    UNCACHED
  } icache_state_e;

endpackage

`default_nettype wire

/* common/icache_fill_if.sv */
`timescale 1ns/10ps
`default_nettype none

// refill write path, controller to tag and data arrays
interface icache_fill_if;

  import icache_pkg::*;

  // one pulse per memory beat
  logic                  we;
  // line being refilled
  logic [IDX_W-1:0]      idx;
  // beat number, selects the word in the line
  logic [WORD_SEL_W-1:0] word;
  // beat payload
  logic [XLEN-1:0]       wdata;
  // one pulse after the last beat
  logic                  tag_we;

  modport ctrl (output we, output idx, output word, output wdata, output tag_we);

  modport tag (input tag_we, input idx);

  modport data (input we, input idx, input word, input wdata);

endinterface

`default_nettype wire

/* icache/icache_tag_array.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array (
  input  wire logic                         clk,
  input  wire logic                         rst,
  // lookup, also the tag written on refill
  input  wire logic [icache_pkg::IDX_W-1:0] lookup_idx_i,
  input  wire logic [icache_pkg::TAG_W-1:0] lookup_tag_i,
  output logic                              hit_o,
  icache_fill_if.tag                        fill
);

  import icache_pkg::*;

  // one valid bit and one tag per line
  logic [NUM_LINES-1:0] valid_q;
  logic [TAG_W-1:0]     tag_q [NUM_LINES];

  // valid bits start cleared
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (fill.tag_we) begin
      valid_q[fill.idx] <= 1'b1;
    end
  end

  // tag stored after the last refill beat
  always_ff @(posedge clk) begin
    if (fill.tag_we) begin
      tag_q[fill.idx] <= lookup_tag_i;
    end
  end

  // direct mapped compare at the lookup index
  assign hit_o = valid_q[lookup_idx_i] && (tag_q[lookup_idx_i] == lookup_tag_i);

endmodule

`default_nettype wire

/* icache/icache_data_array.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_data_array (
  input  wire logic                              clk,
  // read address
  input  wire logic [icache_pkg::IDX_W-1:0]      lookup_idx_i,
  input  wire logic [icache_pkg::WORD_SEL_W-1:0] lookup_word_i,
  output logic      [icache_pkg::XLEN-1:0]       word_o,
  icache_fill_if.data                            fill
);

  import icache_pkg::*;

  // 128 lines x 16 words, flat
  logic [XLEN-1:0] mem_q [NUM_LINES*WORDS_PER_LINE];

  // word address is {line, word}
  logic [IDX_W+WORD_SEL_W-1:0] wr_addr;
  logic [IDX_W+WORD_SEL_W-1:0] rd_addr;

  assign wr_addr = {fill.idx, fill.word};
  assign rd_addr = {lookup_idx_i, lookup_word_i};

  // one word per refill beat
  always_ff @(posedge clk) begin
    if (fill.we) begin
      mem_q[wr_addr] <= fill.wdata;
    end
  end

  // asynchronous read, hit data valid in the lookup cycle
  assign word_o = mem_q[rd_addr];

endmodule

`default_nettype wire

/* icache/icache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl (
  input  wire logic                              clk,
  input  wire logic                              rst,
  // cpu fetch request
  input  wire logic [icache_pkg::XLEN-1:0]       fetch_addr_i,
  input  wire logic                              fetch_valid_i,
  // lookup results from the arrays
  input  wire logic                              hit_i,
  input  wire logic [icache_pkg::XLEN-1:0]       line_word_i,
  // memory beats
  input  wire logic                              mem_beat_i,
  input  wire logic [icache_pkg::XLEN-1:0]       mem_rdata_i,
  // lookup address to the arrays
  output logic      [icache_pkg::IDX_W-1:0]      lookup_idx_o,
  output logic      [icache_pkg::TAG_W-1:0]      lookup_tag_o,
  output logic      [icache_pkg::WORD_SEL_W-1:0] lookup_word_o,
  // fetch response
  output logic      [icache_pkg::XLEN-1:0]       fetch_rdata_o,
  output logic                                   fetch_rdata_valid_o,
  // memory request, held until the last beat
  output logic      [icache_pkg::XLEN-1:0]       mem_raddr_o,
  output logic                                   mem_req_valid_o,
  output logic      [icache_pkg::MEM_LEN_W-1:0]  mem_rlen_o,
  icache_fill_if.ctrl                            fill
);

  import icache_pkg::*;

  icache_state_e state_q;

  // fetch address under lookup
  logic [XLEN-1:0] addr_q;
  logic [TAG_W-1:0] addr_tag;
  logic [IDX_W-1:0] addr_idx;
  logic [OFS_W-1:0] addr_ofs;

  // memory request registers
  logic                  mem_req_valid_q;
  logic [XLEN-1:0]       mem_raddr_q;
  logic [MEM_LEN_W-1:0]  mem_rlen_q;
  logic [WORD_SEL_W-1:0] beat_cnt_q;
  logic                  last_beat;

  // tag write strobe, one cycle after the last beat
  logic tag_we_q;

  // uncached word and its one cycle return flag
  logic [XLEN-1:0] unc_data_q;
  logic            unc_ready_q;

  logic uncached;
  logic lookup_hit;

  assign {addr_tag, addr_idx, addr_ofs} = addr_q;

  // device window decode on the registered address
  assign uncached = (addr_q[XLEN-1 -: $bits(UNCACHED_REGION)] == UNCACHED_REGION);

  // device addresses never count as hits
  assign lookup_hit = (state_q == LOOKUP) && hit_i && !uncached;

  // burst ends when the counter reaches the length field
  assign last_beat = (beat_cnt_q == mem_rlen_q[WORD_SEL_W-1:0]);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q         <= RESET;
      mem_req_valid_q <= 1'b0;
      tag_we_q        <= 1'b0;
      unc_ready_q     <= 1'b0;
      beat_cnt_q      <= '0;
    end else begin
      case (state_q)
        RESET: begin
          state_q <= IDLE;
        end
        IDLE: begin
          // both pulses last only the first idle cycle
          tag_we_q    <= 1'b0;
          unc_ready_q <= 1'b0;
          if (fetch_valid_i) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (lookup_hit) begin
            // back to back hits stay here
            if (!fetch_valid_i) begin
              state_q <= IDLE;
            end
          end else if (uncached) begin
            state_q         <= UNCACHED;
            mem_req_valid_q <= 1'b1;
          end else begin
            state_q         <= MISS;
            mem_req_valid_q <= 1'b1;
            beat_cnt_q      <= '0;
          end
        end
        MISS: begin
          // beats arrive with arbitrary gaps
          if (mem_beat_i) begin
            if (last_beat) begin
              state_q         <= IDLE;
              mem_req_valid_q <= 1'b0;
              tag_we_q        <= 1'b1;
            end else begin
              beat_cnt_q <= beat_cnt_q + 1'b1;
            end
          end
        end
        UNCACHED: begin
          if (mem_beat_i) begin
            state_q         <= IDLE;
            mem_req_valid_q <= 1'b0;
            unc_ready_q     <= 1'b1;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    // sample in idle, and after every hit for the next fetch
    if (state_q == IDLE || lookup_hit) begin
      addr_q <= fetch_addr_i;
    end
    // request set up on the edge leaving lookup
    if (state_q == LOOKUP && !lookup_hit) begin
      if (uncached) begin
        mem_raddr_q <= addr_q;
        mem_rlen_q  <= SINGLE_LEN;
      end else begin
        // line aligned refill address
        mem_raddr_q <= {addr_tag, addr_idx, {OFS_W{1'b0}}};
        mem_rlen_q  <= REFILL_LEN;
      end
    end
    if (state_q == UNCACHED && mem_beat_i) begin
      unc_data_q <= mem_rdata_i;
    end
  end

  // lookup address, word select drops the byte bits
  assign lookup_idx_o  = addr_idx;
  assign lookup_tag_o  = addr_tag;
  assign lookup_word_o = addr_ofs[OFS_W-1:2];

  // refill writes go straight from the beat strobe
  assign fill.we     = (state_q == MISS) && mem_beat_i;
  assign fill.idx    = addr_idx;
  assign fill.word   = beat_cnt_q;
  assign fill.wdata  = mem_rdata_i;
  assign fill.tag_we = tag_we_q;

  // response mux
  assign fetch_rdata_o       = unc_ready_q ? unc_data_q : line_word_i;
  assign fetch_rdata_valid_o = lookup_hit || unc_ready_q;

  assign mem_raddr_o     = mem_raddr_q;
  assign mem_req_valid_o = mem_req_valid_q;
  assign mem_rlen_o      = mem_rlen_q;

endmodule

`default_nettype wire

/* icache/icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_top (
  input  wire logic                             clk,
  input  wire logic                             rst,
  // cpu fetch side
  input  wire logic [icache_pkg::XLEN-1:0]      fetch_addr_i,
  input  wire logic                             fetch_valid_i,
  output logic      [icache_pkg::XLEN-1:0]      fetch_rdata_o,
  output logic                                  fetch_rdata_valid_o,
  // memory read side
  output logic      [icache_pkg::XLEN-1:0]      mem_raddr_o,
  output logic                                  mem_req_valid_o,
  output logic      [icache_pkg::MEM_LEN_W-1:0] mem_rlen_o,
  input  wire logic                             mem_beat_i,
  input  wire logic [icache_pkg::XLEN-1:0]      mem_rdata_i
);

  import icache_pkg::*;

  // lookup path, driven from the registered fetch address
  logic [IDX_W-1:0]      lookup_idx;
  logic [TAG_W-1:0]      lookup_tag;
  logic [WORD_SEL_W-1:0] lookup_word;
  logic                  hit;
  logic [XLEN-1:0]       line_word;

  // refill writes
  icache_fill_if fill ();

  icache_ctrl u_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr_i),
    .fetch_valid_i       (fetch_valid_i),
    .hit_i               (hit),
    .line_word_i         (line_word),
    .mem_beat_i          (mem_beat_i),
    .mem_rdata_i         (mem_rdata_i),
    .lookup_idx_o        (lookup_idx),
    .lookup_tag_o        (lookup_tag),
    .lookup_word_o       (lookup_word),
    .fetch_rdata_o       (fetch_rdata_o),
    .fetch_rdata_valid_o (fetch_rdata_valid_o),
    .mem_raddr_o         (mem_raddr_o),
    .mem_req_valid_o     (mem_req_valid_o),
    .mem_rlen_o          (mem_rlen_o),
    .fill                (fill.ctrl)
  );

  icache_tag_array u_tag_array (
    .clk          (clk),
    .rst          (rst),
    .lookup_idx_i (lookup_idx),
    .lookup_tag_i (lookup_tag),
    .hit_o        (hit),
    .fill         (fill.tag)
  );

  icache_data_array u_data_array (
    .clk           (clk),
    .lookup_idx_i  (lookup_idx),
    .lookup_word_i (lookup_word),
    .word_o        (line_word),
    .fill          (fill.data)
  );

endmodule

`default_nettype wire

/* test/tb_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

// behavioral memory behind the cache read port
module tb_mem_model (
  input  wire logic        clk,
  input  wire logic        rst,
  // request from the cache, held until the last beat
  input  wire logic        req_valid_i,
  input  wire logic [31:0] raddr_i,
  input  wire logic [7:0]  rlen_i,
  // beat strobes, driven on the falling edge
  output logic             beat_o,
  output logic [31:0]      rdata_o,
  // request log seen by the testbench
  output logic [31:0]      req_count_o,
  output logic [31:0]      last_raddr_o,
  output logic [7:0]       last_rlen_o
);

  logic [31:0] lfsr_q;

  // memory content, depends on every address bit
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    word_at = {addr[31:16] ^ addr[15:0], ~addr[15:0]};
  endfunction

  // galois lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // two lfsr bits give a gap of 0 to 3 cycles
  task automatic random_gap(output int gap);
    logic b0;
    logic b1;
    begin
      b0     = lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
      b1     = lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
      gap    = {b1, b0};
    end
  endtask

  initial begin : serve
    int gap;
    int b;
    beat_o       = 1'b0;
    rdata_o      = '0;
    req_count_o  = '0;
    last_raddr_o = '0;
    last_rlen_o  = '0;
    lfsr_q       = 32'h1ebe;
    forever begin
      @(negedge clk);
      if (!rst && req_valid_i) begin
        // log the request before the first beat
        last_raddr_o = raddr_i;
        last_rlen_o  = rlen_i;
        req_count_o  = req_count_o + 1;
        // rlen is beats minus one
        for (b = 0; b <= rlen_i; b++) begin
          random_gap(gap);
          beat_o = 1'b0;
          repeat (gap) @(negedge clk);
          beat_o  = 1'b1;
          rdata_o = word_at(raddr_i + 4 * b);
          @(negedge clk);
        end
        beat_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* test/tb_icache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_icache;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int MAX_ROWS       = 32;

  logic        clk;
  logic        rst;
  logic [31:0] fetch_addr;
  logic        fetch_valid;
  logic [31:0] fetch_rdata;
  logic        fetch_rdata_valid;
  logic [31:0] mem_raddr;
  logic        mem_req_valid;
  logic [7:0]  mem_rlen;
  logic        mem_beat;
  logic [31:0] mem_rdata;
  logic [31:0] req_count;
  logic [31:0] last_raddr;
  logic [7:0]  last_rlen;

  // stimulus table, address plus expected request kind
  logic [31:0] row_addr [MAX_ROWS];
  logic        row_refill [MAX_ROWS];
  logic        row_uncached [MAX_ROWS];
  int          num_rows;

  int error_count;
  int check_count;
  logic timed_out;

  icache_top dut (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_o       (fetch_rdata),
    .fetch_rdata_valid_o (fetch_rdata_valid),
    .mem_raddr_o         (mem_raddr),
    .mem_req_valid_o     (mem_req_valid),
    .mem_rlen_o          (mem_rlen),
    .mem_beat_i          (mem_beat),
    .mem_rdata_i         (mem_rdata)
  );

  tb_mem_model mem_model (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (mem_req_valid),
    .raddr_i      (mem_raddr),
    .rlen_i       (mem_rlen),
    .beat_o       (mem_beat),
    .rdata_o      (mem_rdata),
    .req_count_o  (req_count),
    .last_raddr_o (last_raddr),
    .last_rlen_o  (last_rlen)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // expected memory word for a byte address
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    expected_word = {addr[31:16] ^ addr[15:0], ~addr[15:0]};
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error at %0t: %s: got 0x%h, expected 0x%h", $time, what, actual, expected);
    end
  endtask

  task automatic add_row(input logic [31:0] addr, input logic refill, input logic uncached);
    row_addr[num_rows]     = addr;
    row_refill[num_rows]   = refill;
    row_uncached[num_rows] = uncached;
    num_rows++;
  endtask

  task automatic build_table();
    // line 0x40, tag 0, then hits incl. last word
    add_row(32'h0000_1000, 1'b1, 1'b0);
    add_row(32'h0000_1004, 1'b0, 1'b0);
    add_row(32'h0000_1008, 1'b0, 1'b0);
    add_row(32'h0000_103c, 1'b0, 1'b0);
    add_row(32'h0000_1020, 1'b0, 1'b0);
    // same index, other tag evicts
    add_row(32'h0000_3000, 1'b1, 1'b0);
    add_row(32'h0000_3010, 1'b0, 1'b0);
    add_row(32'h0000_1000, 1'b1, 1'b0);
    add_row(32'h0000_1004, 1'b0, 1'b0);
    // device window, same index, twice
    add_row(32'h1000_1004, 1'b0, 1'b1);
    add_row(32'h1000_1004, 1'b0, 1'b1);
    // line 0x40 must survive the device reads
    add_row(32'h0000_1000, 1'b0, 1'b0);
    // line 0x01 ping pong
    add_row(32'h0000_2040, 1'b1, 1'b0);
    add_row(32'h2000_207c, 1'b1, 1'b0);
    add_row(32'h0000_2044, 1'b1, 1'b0);
    // top index
    add_row(32'h0001_fffc, 1'b1, 1'b0);
    add_row(32'h0001_ffc0, 1'b0, 1'b0);
    add_row(32'h1fff_fffc, 1'b0, 1'b1);
    add_row(32'h0000_1038, 1'b0, 1'b0);
  endtask

  // caller sits on a falling edge, returns on the edge with valid data
  task automatic fetch_word(input logic [31:0] addr, output logic [31:0] data,
                            output int cycles);
    logic got;
    begin
      got         = 1'b0;
      cycles      = 0;
      data        = '0;
      fetch_addr  = addr;
      fetch_valid = 1'b1;
      while (!got && cycles < TIMEOUT_CYCLES) begin
        @(negedge clk);
        cycles++;
        got = fetch_rdata_valid;
      end
      if (got) begin
        data = fetch_rdata;
      end else begin
        timed_out = 1'b1;
        $display("timeout: no fetch data for address 0x%h within %0d cycles",
                 addr, TIMEOUT_CYCLES);
      end
    end
  endtask

  task automatic check_row(input int r, input logic [31:0] data, input int cycles,
                           input logic [31:0] count_before);
    logic [31:0] new_reqs;
    begin
      new_reqs = req_count - count_before;
      check_value(data, expected_word(row_addr[r]), $sformatf("row %0d data", r));
      check_value(new_reqs, (row_refill[r] || row_uncached[r]) ? 1 : 0,
                  $sformatf("row %0d request count", r));
      if (row_refill[r]) begin
        // whole line, 16 beats
        check_value(last_raddr, row_addr[r] & 32'hffff_ffc0, $sformatf("row %0d line addr", r));
        check_value(last_rlen, 15, $sformatf("row %0d refill len", r));
      end else if (row_uncached[r]) begin
        check_value(last_raddr, row_addr[r], $sformatf("row %0d device addr", r));
        check_value(last_rlen, 0, $sformatf("row %0d device len", r));
      end else begin
        // every hit follows a returned word, so one cycle
        check_value(cycles, 1, $sformatf("row %0d hit latency", r));
      end
    end
  endtask

  initial begin : stimulus
    logic [31:0] data;
    logic [31:0] count_before;
    int          cycles;
    int          expected_reqs;
    rst           = 1'b1;
    fetch_addr    = '0;
    fetch_valid   = 1'b0;
    error_count   = 0;
    check_count   = 0;
    timed_out     = 1'b0;
    num_rows      = 0;
    expected_reqs = 0;
    build_table();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    repeat (3) @(negedge clk);
    // quiet after reset, nothing requested yet
    check_value(fetch_rdata_valid, 0, "fetch valid after reset");
    check_value(mem_req_valid, 0, "mem request after reset");
    check_value(req_count, 0, "requests before first fetch");
    for (int r = 0; r < num_rows && !timed_out; r++) begin
      count_before = req_count;
      fetch_word(row_addr[r], data, cycles);
      if (!timed_out) begin
        check_row(r, data, cycles, count_before);
        expected_reqs += int'(row_refill[r]) + int'(row_uncached[r]);
      end
    end
    fetch_valid = 1'b0;
    // let the last lookup drain
    repeat (4) @(negedge clk);
    if (!timed_out) begin
      check_value(mem_req_valid, 0, "mem request at end");
      check_value(req_count, expected_reqs, "total requests");
    end
    $display("checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timed_out);
    if (error_count == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
common/icache_pkg.sv
common/icache_fill_if.sv
icache/icache_tag_array.sv
icache/icache_data_array.sv
icache/icache_ctrl.sv
icache/icache_top.sv
test/tb_mem_model.sv
test/tb_icache.sv
